/* elevator_pkg.sv */
package elevator_pkg;

	localparam int NUM_FLOORS   = 8;
	localparam int DWELL_CYCLES = 10;	// cycles the door stays open

	// twice the floor count keeps room for a 16-floor shaft
	localparam int FLOOR_W = $clog2(2 * NUM_FLOORS);

	typedef enum logic [1:0] {
		MOTOR_STOP = 2'd0,
		MOTOR_DOWN = 2'd1,
		MOTOR_UP   = 2'd2
	} motor_t;

	typedef enum logic [1:0] {
		DOOR_HOLD  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_t;

	typedef enum logic [1:0] {
		SENSE_BETWEEN = 2'd0,
		SENSE_OPENED  = 2'd1,
		SENSE_CLOSED  = 2'd2
	} door_sense_t;

	typedef enum logic [2:0] {
		IDLE    = 3'd0,	// stopped, doors closed
		OPENING = 3'd1,
		DWELL   = 3'd2,
		CLOSING = 3'd3,
		MOVING  = 3'd4
	} ctrl_state_t;

endpackage

/* call_if.sv */
`timescale 1ns/1ns

interface call_if;

	import elevator_pkg::*;

	logic				calls_above;	// pending call above the car
	logic				calls_below;	// pending call below the car
	logic				call_here;		// pending call at the car
	logic				clear_here;		// served, drop call at car_floor
	logic [FLOOR_W-1:0]	car_floor;

	modport registry (
		input	car_floor,
		input	clear_here,
		output	calls_above,
		output	calls_below,
		output	call_here
	);

	modport controller (
		input	calls_above,
		input	calls_below,
		input	call_here,
		output	clear_here
	);

endinterface

/* call_register.sv */
`timescale 1ns/1ns

module call_register #(
	parameter int NUM_FLOORS = elevator_pkg::NUM_FLOORS
) (
	input	logic					i_clock,
	input	logic					i_an_reset,
	input	logic					i_block,
	input	logic [NUM_FLOORS-1:0]	i_car_btn,
	input	logic [NUM_FLOORS-1:0]	i_hall_up,
	input	logic [NUM_FLOORS-1:0]	i_hall_down,
	call_if.registry				calls
);

	import elevator_pkg::*;

	logic [NUM_FLOORS-1:0]	pending;	// one call bit per floor
	logic [NUM_FLOORS-1:0]	press;
	logic					above;
	logic					below;
	logic					here;

	assign press = i_car_btn | i_hall_up | i_hall_down;

	always_ff @(posedge i_clock or negedge i_an_reset) begin
		if (!i_an_reset) begin
			pending <= '0;
		end
		else if (i_block) begin
			pending <= '0;	// blocked, drop everything
		end
		else begin
			for (int f = 0; f < NUM_FLOORS; f++) begin
				if (calls.clear_here && calls.car_floor == FLOOR_W'(f))
					pending[f] <= 1'b0;
				if (press[f])
					pending[f] <= 1'b1;	// press beats clear
			end
		end
	end

	always_comb begin
		above = 1'b0;
		below = 1'b0;
		here  = 1'b0;
		for (int f = 0; f < NUM_FLOORS; f++) begin
			if (FLOOR_W'(f) > calls.car_floor)
				above = above | pending[f];
			else if (FLOOR_W'(f) < calls.car_floor)
				below = below | pending[f];
			else
				here = here | pending[f];
		end
	end

	assign calls.calls_above = above;
	assign calls.calls_below = below;
	assign calls.call_here   = here;

endmodule

/* shaft_position.sv */
`timescale 1ns/1ns

module shaft_position #(
	parameter int NUM_FLOORS = elevator_pkg::NUM_FLOORS
) (
	input	logic							i_clock,
	input	logic							i_an_reset,
	input	logic							i_block,
	input	logic							i_sensor_up,
	input	logic							i_sensor_down,
	input	elevator_pkg::motor_t			i_motor,
	output	logic [elevator_pkg::FLOOR_W-1:0]	o_floor,
	output	logic							o_arrive,
	output	logic [3:0]						o_level_display
);

	import elevator_pkg::*;

	localparam logic [FLOOR_W-1:0] TOP_FLOOR = FLOOR_W'(NUM_FLOORS - 1);

	logic	reached;
	logic	reached_d;
	logic	reached_rise;

	assign reached      = i_sensor_up & i_sensor_down;
	assign reached_rise = reached & !reached_d;

	always_ff @(posedge i_clock or negedge i_an_reset) begin
		if (!i_an_reset) begin
			reached_d <= 1'b0;
			o_arrive  <= 1'b0;
			o_floor   <= '0;
		end
		else begin
			reached_d <= reached;
			o_arrive  <= reached_rise;
			if (reached_rise) begin
				if (i_motor == MOTOR_UP && o_floor != TOP_FLOOR)
					o_floor <= o_floor + 1'b1;
				else if (i_motor == MOTOR_DOWN && o_floor != '0)
					o_floor <= o_floor - 1'b1;	// saturate at ground
			end
		end
	end

	assign o_level_display = i_block ? 4'd15 : 4'(o_floor);	// 15 flags blocked

endmodule

/* dwell_timer.sv */
`timescale 1ns/1ns

module dwell_timer #(
	parameter int DWELL_CYCLES = elevator_pkg::DWELL_CYCLES
) (
	input	logic	i_clock,
	input	logic	i_an_reset,
	input	logic	i_start,
	output	logic	o_done
);

	localparam int CNT_W = $clog2(DWELL_CYCLES + 1);

	logic [CNT_W-1:0]	count;

	// load one short so done lands DWELL_CYCLES after start
	always_ff @(posedge i_clock or negedge i_an_reset) begin
		if (!i_an_reset) begin
			count <= '0;
		end
		else if (i_start) begin
			count <= CNT_W'(DWELL_CYCLES - 1);
		end
		else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign o_done = (count == '0);	// holds until next start

endmodule

/* car_controller.sv */
`timescale 1ns/1ns

module car_controller (
	input	logic						i_clock,
	input	logic						i_an_reset,
	input	logic						i_block,
	input	elevator_pkg::door_sense_t	i_door_sense,
	input	logic						i_open_btn,
	input	logic						i_close_btn,
	input	logic						i_sensor_inside,
	input	logic						i_overload,
	input	logic						i_arrive,
	input	logic						i_timer_done,
	output	logic						o_timer_start,
	output	elevator_pkg::motor_t		o_motor,
	output	elevator_pkg::door_cmd_t	o_door,
	output	logic						o_direction,
	call_if.controller					ctrl
);

	import elevator_pkg::*;

	ctrl_state_t	state;
	logic			direction;		// 1 up, 0 down
	logic			ahead;
	logic			behind;
	logic			door_opened;
	logic			reopen;

	assign ahead  = direction ? ctrl.calls_above : ctrl.calls_below;
	assign behind = direction ? ctrl.calls_below : ctrl.calls_above;
	assign reopen = i_sensor_inside | i_overload | i_open_btn;

	// doors fully open, passengers served here
	assign door_opened = (state == OPENING) && (i_door_sense == SENSE_OPENED) && !i_block;

	assign ctrl.clear_here = door_opened;
	assign o_timer_start   = door_opened;
	assign o_direction     = direction;

	always_ff @(posedge i_clock or negedge i_an_reset) begin
		if (!i_an_reset) begin
			state     <= IDLE;
			direction <= 1'b1;
			o_motor   <= MOTOR_STOP;
			o_door    <= DOOR_HOLD;
		end
		else if (i_block) begin
			state   <= IDLE;
			o_motor <= MOTOR_STOP;
			o_door  <= DOOR_HOLD;
		end
		else begin
			case (state)
				IDLE: begin
					if (i_door_sense != SENSE_CLOSED) begin
						state  <= CLOSING;	// shut doors left open by a block
						o_door <= DOOR_CLOSE;
					end
					else if (ctrl.call_here) begin
						state  <= OPENING;
						o_door <= DOOR_OPEN;
					end
					else if (ahead) begin
						state   <= MOVING;
						o_motor <= direction ? MOTOR_UP : MOTOR_DOWN;
					end
					else if (behind) begin
						state     <= MOVING;
						direction <= !direction;
						o_motor   <= direction ? MOTOR_DOWN : MOTOR_UP;
					end
				end

				OPENING: begin
					if (i_door_sense == SENSE_OPENED) begin
						state  <= DWELL;
						o_door <= DOOR_HOLD;
					end
					else begin
						o_door <= DOOR_OPEN;
					end
				end

				DWELL: begin
					if (i_close_btn || i_timer_done) begin
						state  <= CLOSING;
						o_door <= DOOR_CLOSE;
					end
				end

				CLOSING: begin
					if (reopen) begin
						state  <= OPENING;
						o_door <= DOOR_OPEN;
					end
					else if (i_door_sense == SENSE_CLOSED) begin
						state  <= IDLE;
						o_door <= DOOR_HOLD;
					end
				end

				MOVING: begin
					if (i_arrive) begin
						if (ctrl.call_here) begin
							state   <= OPENING;
							o_motor <= MOTOR_STOP;
							o_door  <= DOOR_OPEN;
						end
						else if (!ahead) begin
							state   <= IDLE;	// nothing left this way
							o_motor <= MOTOR_STOP;
						end
					end
				end

				default: begin
					state   <= IDLE;
					o_motor <= MOTOR_STOP;
					o_door  <= DOOR_HOLD;
				end
			endcase
		end
	end

endmodule

/* elevator_top.sv */
`timescale 1ns/1ns

module elevator_top #(
	parameter int NUM_FLOORS   = elevator_pkg::NUM_FLOORS,
	parameter int DWELL_CYCLES = elevator_pkg::DWELL_CYCLES
) (
	input	logic					i_clock,
	input	logic					i_an_reset,
	input	logic					i_buttons_block,
	input	logic					i_open_btn,
	input	logic					i_close_btn,
	input	logic					i_overload,
	input	logic					i_sensor_up,
	input	logic					i_sensor_down,
	input	logic					i_sensor_inside,
	input	logic [1:0]				i_sensor_door,	// 0 between, 1 opened, 2 closed
	input	logic [NUM_FLOORS-1:0]	i_btn_in,
	input	logic [NUM_FLOORS-1:0]	i_btn_up_out,
	input	logic [NUM_FLOORS-1:0]	i_btn_down_out,
	output	logic [1:0]				o_engine,		// 0 stop, 1 down, 2 up
	output	logic [1:0]				o_door,			// 0 hold, 1 open, 2 close
	output	logic					o_direction,
	output	logic [3:0]				o_level_display
);

	import elevator_pkg::*;

	motor_t			motor;
	door_sense_t	door_sense;
	logic			arrive;
	logic			timer_start;
	logic			timer_done;

	call_if calls ();

	assign door_sense = door_sense_t'(i_sensor_door);
	assign o_engine   = motor;

	call_register #(
		.NUM_FLOORS	(NUM_FLOORS)
	) call_register0 (
		.i_clock		(i_clock),
		.i_an_reset		(i_an_reset),
		.i_block		(i_buttons_block),
		.i_car_btn		(i_btn_in),
		.i_hall_up		(i_btn_up_out),
		.i_hall_down	(i_btn_down_out),
		.calls			(calls.registry)
	);

	shaft_position #(
		.NUM_FLOORS	(NUM_FLOORS)
	) shaft_position0 (
		.i_clock			(i_clock),
		.i_an_reset			(i_an_reset),
		.i_block			(i_buttons_block),
		.i_sensor_up		(i_sensor_up),
		.i_sensor_down		(i_sensor_down),
		.i_motor			(motor),
		.o_floor			(calls.car_floor),
		.o_arrive			(arrive),
		.o_level_display	(o_level_display)
	);

	dwell_timer #(
		.DWELL_CYCLES	(DWELL_CYCLES)
	) dwell_timer0 (
		.i_clock	(i_clock),
		.i_an_reset	(i_an_reset),
		.i_start	(timer_start),
		.o_done		(timer_done)
	);

	car_controller car_controller0 (
		.i_clock			(i_clock),
		.i_an_reset			(i_an_reset),
		.i_block			(i_buttons_block),
		.i_door_sense		(door_sense),
		.i_open_btn			(i_open_btn),
		.i_close_btn		(i_close_btn),
		.i_sensor_inside	(i_sensor_inside),
		.i_overload			(i_overload),
		.i_arrive			(arrive),
		.i_timer_done		(timer_done),
		.o_timer_start		(timer_start),
		.o_motor			(motor),
		.o_door				(o_door),
		.o_direction		(o_direction),
		.ctrl				(calls.controller)
	);

endmodule

/* elevator_sva.sv */
`timescale 1ns/1ns

module elevator_sva #(
	parameter int DWELL_CYCLES = elevator_pkg::DWELL_CYCLES
) (
	input	logic		i_clock,
	input	logic		i_an_reset,
	input	logic		i_buttons_block,
	input	logic		i_open_btn,
	input	logic		i_close_btn,
	input	logic		i_overload,
	input	logic		i_sensor_inside,
	input	logic [1:0]	i_sensor_door,
	input	logic [1:0]	o_engine,
	input	logic [1:0]	o_door,
	input	logic		o_direction,
	input	logic [3:0]	o_level_display,
	input	logic		timer_start,
	input	logic		timer_done
);

	int			errors = 0;
	logic [7:0]	dwell_age;	// cycles since timer start, no close press

	always_ff @(posedge i_clock or negedge i_an_reset) begin
		if (!i_an_reset) begin
			dwell_age <= '0;
		end
		else if (i_buttons_block) begin
			dwell_age <= '0;
		end
		else if (timer_start) begin
			dwell_age <= 8'd1;
		end
		else if (dwell_age != '0) begin
			if (i_close_btn || dwell_age == 8'(DWELL_CYCLES + 1))
				dwell_age <= '0;
			else
				dwell_age <= dwell_age + 8'd1;
		end
	end

	a_safe_motion: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		o_engine != 2'd0 |-> o_door == 2'd0 && i_sensor_door == 2'd2)
		else begin errors++; $error("engine runs while door not closed"); end

	a_direction: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		o_engine != 2'd0 |-> o_direction == (o_engine == 2'd2))
		else begin errors++; $error("direction does not match engine"); end

	a_block_idle: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		i_buttons_block |=> (!i_buttons_block || (o_engine == 2'd0 && o_door == 2'd0)))
		else begin errors++; $error("engine or door active while blocked"); end

	a_block_display: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		i_buttons_block |-> o_level_display == 4'd15)
		else begin errors++; $error("display not 15 while blocked"); end

	a_reopen: assert property (@(posedge i_clock)
		disable iff (!i_an_reset || i_buttons_block)
		o_door == 2'd2 && (i_sensor_inside || i_open_btn || i_overload) |=> o_door == 2'd1)
		else begin errors++; $error("closing door did not reopen"); end

	a_timer_early: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		timer_start |=> !timer_done)
		else begin errors++; $error("dwell timer done too early"); end

	a_timer_length: assert property (@(posedge i_clock) disable iff (!i_an_reset)
		timer_start |-> ##DWELL_CYCLES timer_done)
		else begin errors++; $error("dwell timer not done in time"); end

	a_dwell_hold: assert property (@(posedge i_clock)
		disable iff (!i_an_reset || i_buttons_block)
		dwell_age != '0 && dwell_age <= 8'(DWELL_CYCLES) |-> o_door == 2'd0)
		else begin errors++; $error("door moved during dwell"); end

	a_dwell_cut: assert property (@(posedge i_clock)
		disable iff (!i_an_reset || i_buttons_block)
		dwell_age != '0 && dwell_age <= 8'(DWELL_CYCLES) && i_close_btn |=> o_door == 2'd2)
		else begin errors++; $error("close button did not end dwell"); end

	a_dwell_close: assert property (@(posedge i_clock)
		disable iff (!i_an_reset || i_buttons_block)
		dwell_age == 8'(DWELL_CYCLES + 1) |-> o_door == 2'd2)
		else begin errors++; $error("door not closing after dwell"); end

endmodule

bind elevator_top elevator_sva #(
	.DWELL_CYCLES	(DWELL_CYCLES)
) sva0 (
	.i_clock			(i_clock),
	.i_an_reset			(i_an_reset),
	.i_buttons_block	(i_buttons_block),
	.i_open_btn			(i_open_btn),
	.i_close_btn		(i_close_btn),
	.i_overload			(i_overload),
	.i_sensor_inside	(i_sensor_inside),
	.i_sensor_door		(i_sensor_door),
	.o_engine			(o_engine),
	.o_door				(o_door),
	.o_direction		(o_direction),
	.o_level_display	(o_level_display),
	.timer_start		(timer_start),
	.timer_done			(timer_done)
);

/* elevator_tb.sv */
`timescale 1ns/1ns

module elevator_tb;

	import elevator_pkg::*;

	localparam int N          = NUM_FLOORS;
	localparam int MAX_CYCLES = 4000;

	logic			clock = 1'b0;
	logic			an_reset;
	logic			buttons_block;
	logic			open_btn;
	logic			close_btn;
	logic			overload;
	logic			sensor_up;
	logic			sensor_down;
	logic			sensor_inside;
	logic [1:0]		sensor_door;
	logic [N-1:0]	btn_in;
	logic [N-1:0]	btn_up_out;
	logic [N-1:0]	btn_down_out;
	wire [1:0]		engine;
	wire [1:0]		door;
	wire			direction;
	wire [3:0]		level_display;

	int				cycles = 0;
	int				travel_cnt;
	int				door_cnt;
	int				door_time;
	logic [1:0]		last_door;
	logic [1:0]		engine_q;
	logic			reached_q;
	logic [3:0]		exp_floor;
	logic [N-1:0]	pending;

	elevator_top dut0 (
		.i_clock(clock), .i_an_reset(an_reset), .i_buttons_block(buttons_block),
		.i_open_btn(open_btn), .i_close_btn(close_btn), .i_overload(overload),
		.i_sensor_up(sensor_up), .i_sensor_down(sensor_down),
		.i_sensor_inside(sensor_inside), .i_sensor_door(sensor_door),
		.i_btn_in(btn_in), .i_btn_up_out(btn_up_out), .i_btn_down_out(btn_down_out),
		.o_engine(engine), .o_door(door), .o_direction(direction),
		.o_level_display(level_display)
	);

	always #5 clock = ~clock;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	task automatic mismatch(input string msg);
		stop_run($sformatf("Mismatch at %0t: %s", $time, msg));
	endtask

	task automatic wait_door(input logic [1:0] cmd);
		do @(negedge clock); while (door != cmd);
	endtask

	task automatic press(input int kind, input int f);	// 0 car, 1 hall up, 2 hall down
		@(posedge clock);
		if (kind == 0) btn_in[f] <= 1'b1;
		else if (kind == 1) btn_up_out[f] <= 1'b1;
		else btn_down_out[f] <= 1'b1;
		pending[f] = 1'b1;
		@(posedge clock);
		btn_in       <= '0;
		btn_up_out   <= '0;
		btn_down_out <= '0;
	endtask

	task automatic pulse_input(input int which);	// 0 sensor_inside, 1 open, 2 close
		@(posedge clock);
		if (which == 0) sensor_inside <= 1'b1;
		else if (which == 1) open_btn <= 1'b1;
		else close_btn <= 1'b1;
		@(posedge clock);
		sensor_inside <= 1'b0;
		open_btn      <= 1'b0;
		close_btn     <= 1'b0;
	endtask

	// door opening marks the stop, then let it run through to closed
	task automatic serve_stop(input int f);
		wait_door(2'd1);
		assert (engine == 2'd0 && exp_floor == 4'(f))
			else mismatch($sformatf("stop at floor %0d, expected %0d", exp_floor, f));
		wait_door(2'd2);
		pending[f] = 1'b0;
		wait_door(2'd0);
	endtask

	// shaft and door plant
	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			stop_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
		if (an_reset) begin
			if (engine != 2'd0) begin
				travel_cnt <= travel_cnt + 1;
				if (travel_cnt == 4) begin
					sensor_up   <= 1'b1;
					sensor_down <= 1'b1;
				end
				if (travel_cnt == 6) begin
					sensor_up   <= 1'b0;
					sensor_down <= 1'b0;
					travel_cnt  <= 0;
				end
			end
			else begin
				travel_cnt  <= 0;
				sensor_up   <= 1'b0;
				sensor_down <= 1'b0;
			end
			last_door <= door;
			if (door != last_door) begin
				door_cnt <= 0;
			end
			else if ((door == 2'd1 && sensor_door != 2'd1) ||
					(door == 2'd2 && sensor_door != 2'd2)) begin
				sensor_door <= 2'd0;
				door_cnt    <= door_cnt + 1;
				if (door_cnt + 1 >= door_time) begin
					sensor_door <= door;	// cmd open/close maps to opened/closed
					door_cnt    <= 0;
					door_time   <= 2 + int'($urandom % 5);
				end
			end
			reached_q <= sensor_up & sensor_down;
			if (sensor_up && sensor_down && !reached_q) begin
				if (engine == 2'd2 && exp_floor != 4'(N - 1))
					exp_floor <= exp_floor + 4'd1;
				else if (engine == 2'd1 && exp_floor != 4'd0)
					exp_floor <= exp_floor - 4'd1;
			end
		end
	end

	always @(negedge clock) begin
		if (an_reset && !buttons_block)
			assert (level_display == exp_floor)
				else mismatch($sformatf("display %0d, expected %0d", level_display, exp_floor));
		if (an_reset && !buttons_block && engine == 2'd0 && engine_q != 2'd0)
			assert (pending[int'(exp_floor)])
				else mismatch($sformatf("car stopped at floor %0d without a call", exp_floor));
		engine_q = engine;
		if (dut0.sva0.errors != 0)
			stop_run("A bound assertion on the DUT failed");
	end

	initial begin
		void'($urandom(9));
		an_reset = 1'b0;
		buttons_block = 1'b0;
		open_btn = 1'b0;
		close_btn = 1'b0;
		overload = 1'b0;
		sensor_up = 1'b0;
		sensor_down = 1'b0;
		sensor_inside = 1'b0;
		sensor_door = 2'd2;	// doors start closed
		btn_in = '0;
		btn_up_out = '0;
		btn_down_out = '0;
		travel_cnt = 0;
		door_cnt = 0;
		door_time = 3;
		last_door = 2'd0;
		engine_q = 2'd0;
		reached_q = 1'b0;
		exp_floor = 4'd0;
		pending = '0;
		repeat (16) @(posedge clock);
		an_reset <= 1'b1;
		@(negedge clock);
		assert (engine == 2'd0 && door == 2'd0 && level_display == 4'd0 && direction == 1'b1)
			else mismatch("outputs not idle after reset");

		press(0, 5);
		serve_stop(5);
		press(0, 0);
		serve_stop(0);

		press(1, 2);
		press(2, 6);
		serve_stop(2);
		do @(negedge clock); while (engine == 2'd0);
		press(1, 1);	// behind the car now
		serve_stop(6);
		serve_stop(1);

		press(0, 1);
		wait_door(2'd1);
		pending[1] = 1'b0;
		wait_door(2'd2);
		pulse_input(0);
		wait_door(2'd1);
		wait_door(2'd2);	// full dwell
		pulse_input(1);
		wait_door(2'd1);
		do @(negedge clock); while (sensor_door != 2'd1);
		pulse_input(2);
		wait_door(2'd2);
		wait_door(2'd0);

		press(0, 4);
		@(posedge clock);
		buttons_block <= 1'b1;
		repeat (20) @(posedge clock);
		buttons_block <= 1'b0;
		pending = '0;
		repeat (60) begin
			@(negedge clock);
			assert (engine == 2'd0) else mismatch("car moved for a call dropped by the block");
		end

		if (dut0.sva0.errors == 0) begin
			$display("All checks passed");
		end
		else begin
			stop_run("A bound assertion on the DUT failed");
		end
		$finish;
	end

endmodule

/* elevator.f */
elevator_pkg.sv
call_if.sv
call_register.sv
shaft_position.sv
dwell_timer.sv
car_controller.sv
elevator_top.sv
elevator_sva.sv
elevator_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the elevator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module elevator_tb \
	--Mdir obj_dir \
	-o elevator_sim \
	-f elevator.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/elevator_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

grep -q "All checks passed" "$LOG"
if [ $? -ne 0 ]; then
	echo "pass message not found in $LOG"
	exit 1
fi

echo "simulation passed"
exit 0
